// ==== hw/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Port count
`define NUM_PORTS 2

// Physical banks, interleaved on the low address bits
`define NUM_BANKS 4

`define DATA_W 32
`define ADDR_W 8

// Bank select and row split of the address
`define BANK_W 2
`define ROW_W 6
`define NUM_ROWS 64

// Read pipeline stages inside a bank
`define RAM_DELAY 2

`endif

// ==== hw/mem_pkg.sv ====
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

  typedef logic [`DATA_W-1:0] data_t;

  typedef logic [`ROW_W-1:0] row_t;

  typedef logic [`BANK_W-1:0] bank_t;

  typedef logic [$clog2(`NUM_PORTS)-1:0] port_t;

  // Physical location of a read, returned alongside the data
  typedef struct packed {
    logic  fwrd;  // Data came from a write in the same cycle
    bank_t bank;
    row_t  row;
  } padr_t;

endpackage

`default_nettype wire

// ==== hw/bank_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

interface bank_if;

  logic                          wr_en;
  logic [`ROW_W-1:0]             wr_row;
  logic [`DATA_W-1:0]            wr_data;
  logic                          rd_en;
  logic [`ROW_W-1:0]             rd_row;
  logic [$clog2(`NUM_PORTS)-1:0] rd_port;  // Requesting port, carried through the bank

  logic                          ret_vld;
  logic [`DATA_W-1:0]            ret_data;
  logic                          ret_fwrd;
  logic [`ROW_W-1:0]             ret_row;
  logic [$clog2(`NUM_PORTS)-1:0] ret_port;

  modport ctrl (
    output wr_en, wr_row, wr_data, rd_en, rd_row, rd_port,
    input  ret_vld, ret_data, ret_fwrd, ret_row, ret_port
  );

  modport bank (
    input  wr_en, wr_row, wr_data, rd_en, rd_row, rd_port,
    output ret_vld, ret_data, ret_fwrd, ret_row, ret_port
  );

endinterface

`default_nettype wire

// ==== hw/port_scheduler.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module port_scheduler (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`NUM_PORTS-1:0]               req_vld,
  input  logic [`NUM_PORTS-1:0]               req_write,
  input  logic [`NUM_PORTS-1:0][`ADDR_W-1:0]  req_addr,
  input  mem_pkg::data_t [`NUM_PORTS-1:0]     req_din,
  output logic [`NUM_PORTS-1:0]               req_rdy,
  output logic                                ready,
  bank_if.ctrl                                banks [`NUM_BANKS]
);

  import mem_pkg::*;

  bank_t                 req_bank [`NUM_PORTS];
  row_t                  req_row [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] acc;
  row_t                  init_row;

  logic  wr_en_n [`NUM_BANKS];
  row_t  wr_row_n [`NUM_BANKS];
  data_t wr_data_n [`NUM_BANKS];
  logic  rd_en_n [`NUM_BANKS];
  row_t  rd_row_n [`NUM_BANKS];
  port_t rd_port_n [`NUM_BANKS];

  logic  wr_en_q [`NUM_BANKS];
  row_t  wr_row_q [`NUM_BANKS];
  data_t wr_data_q [`NUM_BANKS];
  logic  rd_en_q [`NUM_BANKS];
  row_t  rd_row_q [`NUM_BANKS];
  port_t rd_port_q [`NUM_BANKS];

  always_comb begin
    for (int p = 0; p < `NUM_PORTS; p++) begin
      req_bank[p] = req_addr[p][`BANK_W-1:0];       // Low bits pick the bank
      req_row[p]  = req_addr[p][`ADDR_W-1:`BANK_W];
    end
  end

  // A port stalls when a lower port asks for the same bank with the same operation
  always_comb begin
    for (int p = 0; p < `NUM_PORTS; p++) begin
      req_rdy[p] = ready;
      for (int q = 0; q < p; q++) begin
        if (req_vld[q] && (req_write[q] == req_write[p]) && (req_bank[q] == req_bank[p])) begin
          req_rdy[p] = 1'b0;
        end
      end
    end
    acc = req_vld & req_rdy;
  end

  always_comb begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      wr_en_n[b]   = !ready;  // Zero sweep writes every bank at once
      wr_row_n[b]  = init_row;
      wr_data_n[b] = '0;
      rd_en_n[b]   = 1'b0;
      rd_row_n[b]  = '0;
      rd_port_n[b] = '0;
      for (int p = `NUM_PORTS-1; p >= 0; p--) begin  // Lowest port is applied last and wins
        if (acc[p] && (req_bank[p] == bank_t'(b))) begin
          if (req_write[p]) begin
            wr_en_n[b]   = 1'b1;
            wr_row_n[b]  = req_row[p];
            wr_data_n[b] = req_din[p];
          end else begin
            rd_en_n[b]   = 1'b1;
            rd_row_n[b]  = req_row[p];
            rd_port_n[b] = port_t'(p);
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      init_row <= '0;
      ready    <= 1'b0;
    end else if (!ready) begin
      init_row <= init_row + 1'b1;
      if (init_row == row_t'(`NUM_ROWS-1)) begin
        ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
        wr_en_q[b] <= 1'b0;
        rd_en_q[b] <= 1'b0;
      end
    end else begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
        wr_en_q[b] <= wr_en_n[b];
        rd_en_q[b] <= rd_en_n[b];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      wr_row_q[b]  <= wr_row_n[b];
      wr_data_q[b] <= wr_data_n[b];
      rd_row_q[b]  <= rd_row_n[b];
      rd_port_q[b] <= rd_port_n[b];
    end
  end

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : gen_drive
    assign banks[b].wr_en   = wr_en_q[b];
    assign banks[b].wr_row  = wr_row_q[b];
    assign banks[b].wr_data = wr_data_q[b];
    assign banks[b].rd_en   = rd_en_q[b];
    assign banks[b].rd_row  = rd_row_q[b];
    assign banks[b].rd_port = rd_port_q[b];
  end

endmodule

`default_nettype wire

// ==== hw/bank_slice.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module bank_slice (
  input  logic clk,
  input  logic rst,
  bank_if.bank bnk
);

  import mem_pkg::*;

  data_t mem [`NUM_ROWS];

  logic  vld_p [`RAM_DELAY];
  data_t data_p [`RAM_DELAY];
  logic  fwrd_p [`RAM_DELAY];
  row_t  row_p [`RAM_DELAY];
  port_t port_p [`RAM_DELAY];

  logic  fwrd;

  // The array still holds the old word during a same-row write
  assign fwrd = bnk.wr_en && bnk.rd_en && (bnk.wr_row == bnk.rd_row);

  always_ff @(posedge clk) begin
    if (bnk.wr_en) begin
      mem[bnk.wr_row] <= bnk.wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RAM_DELAY; i++) begin
        vld_p[i] <= 1'b0;
      end
    end else begin
      vld_p[0] <= bnk.rd_en;
      for (int i = 1; i < `RAM_DELAY; i++) begin
        vld_p[i] <= vld_p[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    data_p[0] <= fwrd ? bnk.wr_data : mem[bnk.rd_row];
    fwrd_p[0] <= fwrd;
    row_p[0]  <= bnk.rd_row;
    port_p[0] <= bnk.rd_port;
    for (int i = 1; i < `RAM_DELAY; i++) begin
      data_p[i] <= data_p[i-1];
      fwrd_p[i] <= fwrd_p[i-1];
      row_p[i]  <= row_p[i-1];
      port_p[i] <= port_p[i-1];
    end
  end

  assign bnk.ret_vld  = vld_p[`RAM_DELAY-1];
  assign bnk.ret_data = data_p[`RAM_DELAY-1];
  assign bnk.ret_fwrd = fwrd_p[`RAM_DELAY-1];
  assign bnk.ret_row  = row_p[`RAM_DELAY-1];
  assign bnk.ret_port = port_p[`RAM_DELAY-1];

endmodule

`default_nettype wire

// ==== hw/read_collector.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module read_collector (
  input  logic                             clk,
  input  logic                             rst,
  bank_if.ctrl                             banks [`NUM_BANKS],
  output logic [`NUM_PORTS-1:0]            rd_vld,
  output mem_pkg::data_t [`NUM_PORTS-1:0]  rd_dout,
  output mem_pkg::padr_t [`NUM_PORTS-1:0]  rd_padr
);

  import mem_pkg::*;

  logic  ret_vld [`NUM_BANKS];
  data_t ret_data [`NUM_BANKS];
  logic  ret_fwrd [`NUM_BANKS];
  row_t  ret_row [`NUM_BANKS];
  port_t ret_port [`NUM_BANKS];

  logic  sel_vld [`NUM_PORTS];
  data_t sel_data [`NUM_PORTS];
  padr_t sel_padr [`NUM_PORTS];

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : gen_ret
    assign ret_vld[b]  = banks[b].ret_vld;
    assign ret_data[b] = banks[b].ret_data;
    assign ret_fwrd[b] = banks[b].ret_fwrd;
    assign ret_row[b]  = banks[b].ret_row;
    assign ret_port[b] = banks[b].ret_port;
  end

  // Only one bank can return to a given port in a cycle
  always_comb begin
    for (int p = 0; p < `NUM_PORTS; p++) begin
      sel_vld[p]  = 1'b0;
      sel_data[p] = '0;
      sel_padr[p] = '0;
      for (int b = 0; b < `NUM_BANKS; b++) begin
        if (ret_vld[b] && (ret_port[b] == port_t'(p))) begin
          sel_vld[p]  = 1'b1;
          sel_data[p] = ret_data[b];
          sel_padr[p] = '{fwrd: ret_fwrd[b], bank: bank_t'(b), row: ret_row[b]};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= '0;
    end else begin
      for (int p = 0; p < `NUM_PORTS; p++) begin
        rd_vld[p] <= sel_vld[p];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `NUM_PORTS; p++) begin
      rd_dout[p] <= sel_data[p];
      rd_padr[p] <= sel_padr[p];
    end
  end

endmodule

`default_nettype wire

// ==== hw/multiport_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module multiport_mem_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`NUM_PORTS-1:0]               req_vld,
  input  logic [`NUM_PORTS-1:0]               req_write,
  input  logic [`NUM_PORTS-1:0][`ADDR_W-1:0]  req_addr,
  input  mem_pkg::data_t [`NUM_PORTS-1:0]     req_din,
  output logic [`NUM_PORTS-1:0]               req_rdy,
  output logic [`NUM_PORTS-1:0]               rd_vld,
  output mem_pkg::data_t [`NUM_PORTS-1:0]     rd_dout,
  output mem_pkg::padr_t [`NUM_PORTS-1:0]     rd_padr,
  output logic                                ready
);

  bank_if bank_bus [`NUM_BANKS] ();

  port_scheduler u_sched (
    .clk       (clk),
    .rst       (rst),
    .req_vld   (req_vld),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_din   (req_din),
    .req_rdy   (req_rdy),
    .ready     (ready),
    .banks     (bank_bus)
  );

  // One 1r1w RAM per bank
  for (genvar b = 0; b < `NUM_BANKS; b++) begin : gen_bank
    bank_slice u_bank (
      .clk (clk),
      .rst (rst),
      .bnk (bank_bus[b])
    );
  end

  read_collector u_coll (
    .clk     (clk),
    .rst     (rst),
    .banks   (bank_bus),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr)
  );

endmodule

`default_nettype wire

// ==== verif/mem_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module mem_tb;

  import mem_pkg::*;

  localparam int SEED          = 43;
  localparam int RST_CYCLES    = 5;
  localparam int RD_LAT        = 4;  // From the request's own cycle to rd_vld
  localparam int READY_TIMEOUT = 200;
  localparam int HOLD_TIMEOUT  = 20;
  localparam int DRAIN_TIMEOUT = 50;
  localparam int RAND_CYCLES   = 300;

  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_WR   = 2'd2;

  typedef struct packed {
    logic [2:0] test;
    logic [1:0] op0;
    logic [7:0] addr0;
    logic [1:0] op1;
    logic [7:0] addr1;
    logic       rdy1;  // Expected port 1 req_rdy in the first cycle of the row
  } stim_t;

  typedef struct packed {
    int    cyc;
    padr_t padr;
    data_t data;
  } exp_t;

  logic                               clk;
  logic                               rst;
  logic [`NUM_PORTS-1:0]              req_vld;
  logic [`NUM_PORTS-1:0]              req_write;
  logic [`NUM_PORTS-1:0][`ADDR_W-1:0] req_addr;
  data_t [`NUM_PORTS-1:0]             req_din;
  logic [`NUM_PORTS-1:0]              req_rdy;
  logic [`NUM_PORTS-1:0]              rd_vld;
  data_t [`NUM_PORTS-1:0]             rd_dout;
  padr_t [`NUM_PORTS-1:0]             rd_padr;
  logic                               ready;

  logic [`NUM_PORTS-1:0]              cur_vld;
  logic [`NUM_PORTS-1:0]              cur_write;
  logic [`NUM_PORTS-1:0][`ADDR_W-1:0] cur_addr;
  data_t [`NUM_PORTS-1:0]             cur_din;
  logic [`NUM_PORTS-1:0]              last_rdy;

  data_t model [1 << `ADDR_W];
  exp_t  exp_q [`NUM_PORTS][$];
  stim_t table_q [$];
  int    cycle = 0;
  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  logic  timed_out = 1'b0;

  multiport_mem_top u_multiport_mem_top (
    .clk       (clk),
    .rst       (rst),
    .req_vld   (req_vld),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_din   (req_din),
    .req_rdy   (req_rdy),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr),
    .ready     (ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // Read returns are matched in order against each port's queue
  always @(negedge clk) begin : monitor
    exp_t e;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (rd_vld[p]) begin
        if (exp_q[p].size() == 0) begin
          $display("Port %0d returned a read at %0t with no read outstanding", p, $time);
          errors++;
        end else begin
          e = exp_q[p].pop_front();
          checks += 3;
          assert (cycle == e.cyc) else begin
            $display("[ERROR] %0t port %0d: rd_vld in cycle %0d, expected %0d", $time, p,
                     cycle, e.cyc);
            errors++;
          end
          assert (rd_dout[p] == e.data) else begin
            $display("[ERROR] %0t port %0d: rd_dout %h, expected %h", $time, p, rd_dout[p],
                     e.data);
            errors++;
          end
          assert (rd_padr[p] == e.padr) else begin
            $display("[ERROR] %0t port %0d: rd_padr %h, expected %h", $time, p, rd_padr[p],
                     e.padr);
            errors++;
          end
        end
      end else if (exp_q[p].size() != 0 && exp_q[p][0].cyc <= cycle) begin
        $display("Port %0d never returned the read due in cycle %0d", p, exp_q[p][0].cyc);
        errors++;
        e = exp_q[p].pop_front();
      end
    end
  end

  function automatic stim_t stim(input logic [2:0] test, input logic [1:0] op0,
                                 input logic [7:0] addr0, input logic [1:0] op1,
                                 input logic [7:0] addr1, input logic rdy1);
    stim_t s;
    s = '{test: test, op0: op0, addr0: addr0, op1: op1, addr1: addr1, rdy1: rdy1};
    return s;
  endfunction

  task automatic load_table();
    table_q.push_back(stim(3'd1, OP_RD, 8'h80, OP_RD, 8'h81, 1'b1));
    table_q.push_back(stim(3'd1, OP_RD, 8'hc2, OP_RD, 8'hff, 1'b1));
    table_q.push_back(stim(3'd2, OP_WR, 8'h10, OP_WR, 8'h21, 1'b1));
    table_q.push_back(stim(3'd2, OP_WR, 8'h33, OP_WR, 8'h46, 1'b1));
    table_q.push_back(stim(3'd2, OP_WR, 8'hfc, OP_WR, 8'h05, 1'b1));
    table_q.push_back(stim(3'd2, OP_RD, 8'h21, OP_RD, 8'h10, 1'b1));
    table_q.push_back(stim(3'd2, OP_RD, 8'h46, OP_RD, 8'h33, 1'b1));
    table_q.push_back(stim(3'd2, OP_RD, 8'h05, OP_RD, 8'hfc, 1'b1));
    table_q.push_back(stim(3'd3, OP_RD, 8'h10, OP_RD, 8'h14, 1'b0));  // Same bank reads
    table_q.push_back(stim(3'd3, OP_WR, 8'h22, OP_WR, 8'h26, 1'b0));  // Same bank writes
    table_q.push_back(stim(3'd3, OP_RD, 8'h21, OP_WR, 8'h25, 1'b1));
    table_q.push_back(stim(3'd3, OP_WR, 8'h37, OP_RD, 8'h33, 1'b1));
    table_q.push_back(stim(3'd3, OP_RD, 8'h26, OP_RD, 8'h25, 1'b1));
    table_q.push_back(stim(3'd4, OP_WR, 8'h48, OP_RD, 8'h48, 1'b1));
    table_q.push_back(stim(3'd4, OP_WR, 8'h9b, OP_RD, 8'h9b, 1'b1));
    table_q.push_back(stim(3'd4, OP_RD, 8'h48, OP_RD, 8'h9b, 1'b1));
    table_q.push_back(stim(3'd5, OP_RD, 8'h10, OP_RD, 8'h21, 1'b1));
    table_q.push_back(stim(3'd5, OP_RD, 8'h33, OP_RD, 8'h46, 1'b1));
    table_q.push_back(stim(3'd5, OP_RD, 8'h05, OP_RD, 8'hfc, 1'b1));
    table_q.push_back(stim(3'd5, OP_RD, 8'h22, OP_RD, 8'h37, 1'b1));
  endtask

  // Drives the pending requests for one cycle and books the accepted ones
  task automatic step();
    logic [`NUM_PORTS-1:0] acc;
    logic                  exp_rdy1;
    logic                  fwd;
    exp_t                  e;
    @(negedge clk);
    req_vld   = cur_vld;
    req_write = cur_write;
    req_addr  = cur_addr;
    req_din   = cur_din;
    #1;
    last_rdy = req_rdy;
    exp_rdy1 = !(cur_vld[0] && (cur_write[0] == cur_write[1]) &&
                 (cur_addr[0][`BANK_W-1:0] == cur_addr[1][`BANK_W-1:0]));
    checks++;
    assert (req_rdy[0] && (req_rdy[1] == exp_rdy1)) else begin
      $display("[ERROR] %0t req_rdy is %b, expected %b1", $time, req_rdy, exp_rdy1);
      errors++;
    end
    acc = cur_vld & req_rdy;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (acc[p] && cur_write[p]) model[cur_addr[p]] = cur_din[p];
    end
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (acc[p] && !cur_write[p]) begin
        fwd = 1'b0;
        for (int q = 0; q < `NUM_PORTS; q++) begin
          if (acc[q] && cur_write[q] && (cur_addr[q] == cur_addr[p])) fwd = 1'b1;
        end
        e.cyc  = cycle + RD_LAT;
        e.data = model[cur_addr[p]];
        e.padr = '{fwrd: fwd, bank: cur_addr[p][`BANK_W-1:0],
                   row: cur_addr[p][`ADDR_W-1:`BANK_W]};
        exp_q[p].push_back(e);
      end
    end
    cur_vld = cur_vld & ~acc;
  endtask

  task automatic run_table(input logic [2:0] test);
    int guard;
    foreach (table_q[i]) begin
      if (table_q[i].test == test) begin
        cur_vld[0]   = (table_q[i].op0 != OP_IDLE);
        cur_write[0] = (table_q[i].op0 == OP_WR);
        cur_addr[0]  = table_q[i].addr0;
        cur_din[0]   = $urandom;
        cur_vld[1]   = (table_q[i].op1 != OP_IDLE);
        cur_write[1] = (table_q[i].op1 == OP_WR);
        cur_addr[1]  = table_q[i].addr1;
        cur_din[1]   = $urandom;
        step();
        checks++;
        assert (last_rdy[1] == table_q[i].rdy1) else begin
          $display("[ERROR] %0t table row %0d: port 1 req_rdy %b, expected %b", $time, i,
                   last_rdy[1], table_q[i].rdy1);
          errors++;
        end
        guard = 0;
        while (cur_vld != '0 && guard < HOLD_TIMEOUT && !timed_out) begin
          step();
          guard++;
        end
        if (cur_vld != '0) begin
          $display("Table row %0d was still refused after %0d cycles", i, HOLD_TIMEOUT);
          timed_out = 1'b1;
          errors++;
        end
      end
    end
    cur_vld = '0;
    step();
  endtask

  function automatic int outstanding();
    return exp_q[0].size() + exp_q[1].size();
  endfunction

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (outstanding() != 0 && cnt < DRAIN_TIMEOUT && !timed_out) begin
      @(negedge clk);
      cnt++;
    end
    if (outstanding() != 0) begin
      $display("Reads were still outstanding after %0d cycles", DRAIN_TIMEOUT);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic report(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - err0);
    end
  endtask

  initial begin
    int unsigned r;
    int          err0;
    int          cnt;
    void'($urandom(SEED));
    rst       = 1'b1;
    req_vld   = '0;
    req_write = '0;
    req_addr  = '0;
    req_din   = '0;
    cur_vld   = '0;
    cur_write = '0;
    cur_addr  = '0;
    cur_din   = '0;
    foreach (model[i]) model[i] = '0;
    load_table();
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    checks++;
    assert (!ready && req_rdy == '0 && rd_vld == '0) else begin
      $display("[ERROR] %0t ready, req_rdy or rd_vld high during reset", $time);
      errors++;
    end
    rst = 1'b0;

    err0 = errors;
    cnt  = 0;
    while (!ready && cnt < READY_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!ready) begin
      $display("ready did not rise within %0d cycles after reset", READY_TIMEOUT);
      timed_out = 1'b1;
      errors++;
    end else begin
      checks++;
      assert (cnt == `NUM_ROWS) else begin
        $display("[ERROR] %0t ready rose after %0d cycles, expected %0d", $time, cnt,
                 `NUM_ROWS);
        errors++;
      end
    end
    run_table(3'd1);
    wait_drain();
    report("1 zero init", err0);

    err0 = errors;
    run_table(3'd2);
    wait_drain();
    report("2 write and read back", err0);

    err0 = errors;
    run_table(3'd3);
    wait_drain();
    report("3 bank conflicts", err0);

    err0 = errors;
    run_table(3'd4);
    wait_drain();
    report("4 same cycle forwarding", err0);

    err0 = errors;
    run_table(3'd5);
    wait_drain();
    report("5 back to back read latency", err0);

    err0 = errors;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      for (int p = 0; p < `NUM_PORTS; p++) begin
        if (!cur_vld[p]) begin
          r            = $urandom;
          cur_vld[p]   = (r[1:0] != 2'd0);
          cur_write[p] = r[2];
          cur_addr[p]  = r[3] ? {4'h0, r[7:4]} : r[15:8];  // Hot range makes conflicts likely
          cur_din[p]   = $urandom;
        end
      end
      step();
    end
    cur_vld = '0;
    step();
    wait_drain();
    report("6 random traffic", err0);

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/mem_pkg.sv
hw/bank_if.sv
hw/port_scheduler.sv
hw/bank_slice.sv
hw/read_collector.sv
hw/multiport_mem_top.sv
verif/mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module mem_tb -o mem_tb_sim
./obj_dir/mem_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation finished without failures"
